// ==== all.f ====
pulp_pkg.sv
rab_cfg_regs.sv
rab_xlat.sv
rab_bridge.sv
mbox_fifo.sv
cluster_ctrl.sv
pulp_core.sv
pulp_ooc.sv
tb_clk_gen.sv
tb_pulp_ooc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pulp_ooc
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_pulp_ooc.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pulp_ooc import pulp_pkg::*; ();

  typedef enum logic [1:0] {KIND_CONF, KIND_BUS, KIND_CL} kind_t;

  typedef struct packed {
    kind_t      kind;
    logic       we;
    addr_t      addr;
    data_t      wdata;
    data_t      exp_rdata;
    logic       exp_err;
    logic [3:0] exp_irq;
    addr_t      exp_maddr;
  } entry_t;

  // exp_irq bits
  localparam logic [3:0] IRQ_NONE  = 4'b0000;
  localparam logic [3:0] IRQ_MISS  = 4'b0001;
  localparam logic [3:0] IRQ_MULTI = 4'b0010;
  localparam logic [3:0] IRQ_PROT  = 4'b0100;
  localparam logic [3:0] IRQ_MBOX  = 4'b1000;

  localparam addr_t MBOX_ADDR = 32'h8000_0040;

  // slice 2 overlaps the top of slice 0 and the bottom of slice 1 while slice 3 stays off
  localparam addr_t      S_FIRST  [4] = '{32'h0000_1000, 32'h0000_2000, 32'h0000_1800, 32'h0000_3000};
  localparam addr_t      S_LAST   [4] = '{32'h0000_1fff, 32'h0000_2fff, 32'h0000_27ff, 32'h0000_3fff};
  localparam addr_t      S_OFFSET [4] = '{32'h4000_0000, 32'h5000_0000, 32'h6000_0000, 32'h7000_0000};
  localparam logic [1:0] S_FLAGS  [4] = '{2'b11, 2'b01, 2'b11, 2'b00};

  logic clk, rst_n;

  addr_t                 slv_addr, mst_addr;
  data_t                 slv_wdata, slv_rdata, mst_wdata, mst_rdata;
  logic                  slv_we, slv_valid, slv_ready, slv_err, slv_rsp_valid, slv_rsp_ready;
  logic                  mst_we, mst_valid, mst_ready, mst_err, mst_rsp_valid, mst_rsp_ready;
  conf_addr_t            conf_addr;
  data_t                 conf_wdata, conf_rdata;
  logic                  conf_we, conf_valid, conf_rsp_valid;
  logic [N_CLUSTERS-1:0] cl_fetch_en, cl_eoc, cl_busy;
  logic                  rab_miss_irq, rab_multi_irq, rab_prot_irq, mbox_irq;

  entry_t      tbl [$];
  data_t       mem [addr_t];
  logic [31:0] lcg_state = 32'hf60e;
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;
  int          miss_cnt = 0;
  int          multi_cnt = 0;
  int          prot_cnt = 0;
  int          mst_vld_cycles = 0;
  int          issue_cnt = 0;
  addr_t       last_maddr = '0;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  pulp_ooc dut0 (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .slv_addr_i           (slv_addr),
    .slv_wdata_i          (slv_wdata),
    .slv_we_i             (slv_we),
    .slv_valid_i          (slv_valid),
    .slv_ready_o          (slv_ready),
    .slv_rdata_o          (slv_rdata),
    .slv_err_o            (slv_err),
    .slv_rsp_valid_o      (slv_rsp_valid),
    .slv_rsp_ready_i      (slv_rsp_ready),
    .mst_addr_o           (mst_addr),
    .mst_wdata_o          (mst_wdata),
    .mst_we_o             (mst_we),
    .mst_valid_o          (mst_valid),
    .mst_ready_i          (mst_ready),
    .mst_rdata_i          (mst_rdata),
    .mst_err_i            (mst_err),
    .mst_rsp_valid_i      (mst_rsp_valid),
    .mst_rsp_ready_o      (mst_rsp_ready),
    .rab_conf_addr_i      (conf_addr),
    .rab_conf_wdata_i     (conf_wdata),
    .rab_conf_we_i        (conf_we),
    .rab_conf_valid_i     (conf_valid),
    .rab_conf_rdata_o     (conf_rdata),
    .rab_conf_rsp_valid_o (conf_rsp_valid),
    .cl_fetch_en_i        (cl_fetch_en),
    .cl_eoc_o             (cl_eoc),
    .cl_busy_o            (cl_busy),
    .rab_miss_irq_o       (rab_miss_irq),
    .rab_multi_irq_o      (rab_multi_irq),
    .rab_prot_irq_o       (rab_prot_irq),
    .mbox_irq_o           (mbox_irq)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // contents of memory never written
  function automatic data_t fill_word(input addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic addr_t xl(input int s, input addr_t a);
    return a - S_FIRST[s] + S_OFFSET[s];
  endfunction

  task automatic report_value(input int idx, input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Error: entry %0d %s got 0x%h expected 0x%h", idx, name, got, exp);
    errors++;
  endtask

  task automatic report_fault(input int idx, input string msg);
    $display("entry %0d: %s", idx, msg);
    errors++;
  endtask

  task automatic add_conf(input logic we, input int idx, input data_t wdata, input data_t exp);
    tbl.push_back('{KIND_CONF, we, addr_t'(idx), wdata, exp, 1'b0, IRQ_NONE, '0});
  endtask

  task automatic add_bus(input logic we, input addr_t addr, input data_t wdata,
                         input data_t exp, input logic err, input logic [3:0] irq,
                         input addr_t maddr);
    tbl.push_back('{KIND_BUS, we, addr, wdata, exp, err, irq, maddr});
  endtask

  task automatic build_table();
    for (int s = 0; s < 4; s++) begin
      add_conf(1'b1, s * 4 + 0, S_FIRST[s], '0);
      add_conf(1'b1, s * 4 + 1, S_LAST[s], '0);
      add_conf(1'b1, s * 4 + 2, S_OFFSET[s], '0);
      add_conf(1'b1, s * 4 + 3, data_t'(S_FLAGS[s]), '0);
    end
    for (int s = 0; s < 4; s++) begin
      add_conf(1'b0, s * 4 + 0, '0, S_FIRST[s]);
      add_conf(1'b0, s * 4 + 1, '0, S_LAST[s]);
      add_conf(1'b0, s * 4 + 2, '0, S_OFFSET[s]);
      add_conf(1'b0, s * 4 + 3, '0, data_t'(S_FLAGS[s]));
    end
    add_bus(1'b1, 32'h1100, 32'hcafe_0001, '0, 1'b0, IRQ_NONE, xl(0, 32'h1100));
    add_bus(1'b0, 32'h1100, '0, 32'hcafe_0001, 1'b0, IRQ_NONE, xl(0, 32'h1100));
    add_bus(1'b1, 32'h1000, 32'h0bad_f00d, '0, 1'b0, IRQ_NONE, xl(0, 32'h1000));
    add_bus(1'b0, 32'h1000, '0, 32'h0bad_f00d, 1'b0, IRQ_NONE, xl(0, 32'h1000));
    add_bus(1'b0, 32'h2900, '0, fill_word(xl(1, 32'h2900)), 1'b0, IRQ_NONE, xl(1, 32'h2900));
    add_bus(1'b1, 32'h2900, 32'h1111_2222, '0, 1'b1, IRQ_PROT, '0);
    add_bus(1'b0, 32'h3100, '0, '0, 1'b1, IRQ_MISS, '0);
    add_bus(1'b0, 32'h0500, '0, '0, 1'b1, IRQ_MISS, '0);
    add_bus(1'b1, 32'h1800, 32'h7777_0000, '0, 1'b0, IRQ_MULTI, xl(0, 32'h1800));
    add_bus(1'b0, 32'h1800, '0, 32'h7777_0000, 1'b0, IRQ_MULTI, xl(0, 32'h1800));
    add_bus(1'b0, 32'h2100, '0, fill_word(xl(1, 32'h2100)), 1'b0, IRQ_MULTI, xl(1, 32'h2100));
    add_bus(1'b1, 32'h2100, 32'h3333_4444, '0, 1'b1, IRQ_PROT, '0);
    for (int i = 0; i < 4; i++) begin
      add_bus(1'b1, MBOX_ADDR, 32'hab00_0000 + data_t'(i), '0, 1'b0, IRQ_MBOX, '0);
    end
    add_bus(1'b1, MBOX_ADDR, 32'hdead_0005, '0, 1'b1, IRQ_MBOX, '0);
    for (int i = 0; i < 4; i++) begin
      add_bus(1'b0, MBOX_ADDR, '0, 32'hab00_0000 + data_t'(i), 1'b0,
              (i < 3) ? IRQ_MBOX : IRQ_NONE, '0);
    end
    add_bus(1'b0, MBOX_ADDR, '0, '0, 1'b1, IRQ_NONE, '0);
    for (int c = 0; c < N_CLUSTERS; c++) begin
      tbl.push_back('{KIND_CL, 1'b0, addr_t'(c), '0, '0, 1'b0, IRQ_NONE, '0});
    end
  endtask

  task automatic run_conf(input int idx, input entry_t e);
    @(posedge clk);
    conf_addr  <= conf_addr_t'(e.addr);
    conf_wdata <= e.wdata;
    conf_we    <= e.we;
    conf_valid <= 1'b1;
    @(posedge clk);
    conf_valid <= 1'b0;
    @(negedge clk);
    if (!conf_rsp_valid) begin
      report_fault(idx, "no configuration response one cycle after the request");
    end
    if (conf_rdata !== e.exp_rdata) begin
      report_value(idx, "rab_conf_rdata_o", conf_rdata, e.exp_rdata);
    end
    @(negedge clk);
    if (conf_rsp_valid) begin
      report_fault(idx, "configuration response lasted more than one cycle");
    end
  endtask

  task automatic run_bus(input int idx, input entry_t e);
    int    lat, miss0, multi0, prot0, vld0, iss0;
    data_t rdata;
    logic  err, mbox_lvl, xlat;
    miss0  = miss_cnt;
    multi0 = multi_cnt;
    prot0  = prot_cnt;
    vld0   = mst_vld_cycles;
    iss0   = issue_cnt;
    xlat   = !e.addr[31] && !e.exp_err;
    @(posedge clk);
    slv_addr  <= e.addr;
    slv_wdata <= e.wdata;
    slv_we    <= e.we;
    slv_valid <= 1'b1;
    do begin
      @(negedge clk);
    end while (!slv_ready);
    @(posedge clk);
    slv_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!slv_rsp_valid);
    rdata    = slv_rdata;
    err      = slv_err;
    mbox_lvl = mbox_irq;
    // the response is taken on the next edge
    @(posedge clk);
    if (rdata !== e.exp_rdata) begin
      report_value(idx, "slv_rdata_o", rdata, e.exp_rdata);
    end
    if (err !== e.exp_err) begin
      report_value(idx, "slv_err_o", 32'(err), 32'(e.exp_err));
    end
    if (mbox_lvl !== e.exp_irq[3]) begin
      report_value(idx, "mbox_irq_o", 32'(mbox_lvl), 32'(e.exp_irq[3]));
    end
    if (miss_cnt - miss0 != int'(e.exp_irq[0])) begin
      report_value(idx, "rab_miss_irq_o pulses", 32'(miss_cnt - miss0), 32'(e.exp_irq[0]));
    end
    if (multi_cnt - multi0 != int'(e.exp_irq[1])) begin
      report_value(idx, "rab_multi_irq_o pulses", 32'(multi_cnt - multi0), 32'(e.exp_irq[1]));
    end
    if (prot_cnt - prot0 != int'(e.exp_irq[2])) begin
      report_value(idx, "rab_prot_irq_o pulses", 32'(prot_cnt - prot0), 32'(e.exp_irq[2]));
    end
    if (xlat) begin
      if (issue_cnt - iss0 != 1) begin
        report_fault(idx, "translated access did not make exactly one master request");
      end else if (last_maddr !== e.exp_maddr) begin
        report_value(idx, "mst_addr_o", last_maddr, e.exp_maddr);
      end
    end else begin
      if (mst_vld_cycles != vld0) begin
        report_fault(idx, "master request valid rose for an access that is not translated");
      end
      if (lat != 1) begin
        report_value(idx, "response latency", 32'(lat), 32'd1);
      end
    end
  endtask

  task automatic run_cluster(input int idx, input entry_t e);
    int                    n;
    int                    c;
    logic [N_CLUSTERS-1:0] exp_eoc;
    c = int'(e.addr[1:0]);
    // clusters run in index order, so every lower one has finished already
    exp_eoc = N_CLUSTERS'((32'd1 << (c + 1)) - 32'd1);
    @(posedge clk);
    cl_fetch_en <= N_CLUSTERS'(1) << c;
    @(posedge clk);
    cl_fetch_en <= '0;
    n = 0;
    @(negedge clk);
    while (cl_busy[c]) begin
      if (cl_eoc[c]) begin
        report_fault(idx, "eoc high while the cluster is busy");
      end
      n++;
      @(negedge clk);
    end
    if (n != int'(CL_RUN_CYCLES)) begin
      report_value(idx, "cl_busy_o cycles", 32'(n), 32'(CL_RUN_CYCLES));
    end
    repeat (3) begin
      if (cl_eoc !== exp_eoc) begin
        report_value(idx, "cl_eoc_o", 32'(cl_eoc), 32'(exp_eoc));
      end
      @(negedge clk);
    end
  endtask

  // interrupt pulses and master valid cycles
  always @(negedge clk) begin
    if (rst_n) begin
      if (rab_miss_irq) miss_cnt++;
      if (rab_multi_irq) multi_cnt++;
      if (rab_prot_irq) prot_cnt++;
      if (mst_valid) mst_vld_cycles++;
    end
  end

  // memory model on the master port with random back-pressure
  initial begin : mst_responder
    logic [31:0] r;
    int          delay;
    addr_t       a;
    data_t       d;
    logic        w;
    mst_ready     = 1'b0;
    mst_rsp_valid = 1'b0;
    mst_rdata     = '0;
    mst_err       = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && mst_valid) begin
        r     = lcg_next();
        delay = int'(r[29:28]);
        repeat (delay) @(negedge clk);
        a          = mst_addr;
        d          = mst_wdata;
        w          = mst_we;
        last_maddr = a;
        issue_cnt++;
        @(posedge clk);
        mst_ready <= 1'b1;
        @(posedge clk);
        mst_ready <= 1'b0;
        if (w) begin
          mem[a] = d;
        end
        mst_rdata     <= w ? '0 : (mem.exists(a) ? mem[a] : fill_word(a));
        mst_rsp_valid <= 1'b1;
        do begin
          @(negedge clk);
        end while (!mst_rsp_ready);
        @(posedge clk);
        mst_rsp_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    slv_addr      = '0;
    slv_wdata     = '0;
    slv_we        = 1'b0;
    slv_valid     = 1'b0;
    slv_rsp_ready = 1'b1;
    conf_addr     = '0;
    conf_wdata    = '0;
    conf_we       = 1'b0;
    conf_valid    = 1'b0;
    cl_fetch_en   = '0;
    build_table();
    limit = tbl.size() * 64;
    wait (rst_n === 1'b1);
    @(negedge clk);
    if (!slv_ready || mst_valid || mst_rsp_ready || slv_rsp_valid || conf_rsp_valid ||
        rab_miss_irq || rab_multi_irq || rab_prot_irq || mbox_irq ||
        cl_busy != '0 || cl_eoc != '0) begin
      report_fault(-1, "outputs not in their reset state");
    end
    for (int i = 0; i < tbl.size(); i++) begin
      case (tbl[i].kind)
        KIND_CONF: run_conf(i, tbl[i]);
        KIND_BUS:  run_bus(i, tbl[i]);
        default:   run_cluster(i, tbl[i]);
      endcase
    end
    repeat (2) @(posedge clk);
    $display("entries %0d, errors %0d", tbl.size(), errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== pulp_ooc.sv ====
`timescale 1ns/100ps
`default_nettype none

module pulp_ooc import pulp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  addr_t                 slv_addr_i,
  input  data_t                 slv_wdata_i,
  input  logic                  slv_we_i,
  input  logic                  slv_valid_i,
  output logic                  slv_ready_o,
  output data_t                 slv_rdata_o,
  output logic                  slv_err_o,
  output logic                  slv_rsp_valid_o,
  input  logic                  slv_rsp_ready_i,

  output addr_t                 mst_addr_o,
  output data_t                 mst_wdata_o,
  output logic                  mst_we_o,
  output logic                  mst_valid_o,
  input  logic                  mst_ready_i,
  input  data_t                 mst_rdata_i,
  input  logic                  mst_err_i,
  input  logic                  mst_rsp_valid_i,
  output logic                  mst_rsp_ready_o,

  input  conf_addr_t            rab_conf_addr_i,
  input  data_t                 rab_conf_wdata_i,
  input  logic                  rab_conf_we_i,
  input  logic                  rab_conf_valid_i,
  output data_t                 rab_conf_rdata_o,
  output logic                  rab_conf_rsp_valid_o,

  // cluster control
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,

  // interrupts
  output logic                  rab_miss_irq_o,
  output logic                  rab_multi_irq_o,
  output logic                  rab_prot_irq_o,
  output logic                  mbox_irq_o
);

  bus_req_t  slv_req, mst_req;
  bus_rsp_t  slv_rsp, mst_rsp;
  conf_req_t conf_req;

  assign slv_req.addr  = slv_addr_i;
  assign slv_req.wdata = slv_wdata_i;
  assign slv_req.we    = slv_we_i;
  assign slv_rdata_o   = slv_rsp.rdata;
  assign slv_err_o     = slv_rsp.err;

  assign mst_addr_o    = mst_req.addr;
  assign mst_wdata_o   = mst_req.wdata;
  assign mst_we_o      = mst_req.we;
  assign mst_rsp.rdata = mst_rdata_i;
  assign mst_rsp.err   = mst_err_i;

  assign conf_req.addr  = rab_conf_addr_i;
  assign conf_req.wdata = rab_conf_wdata_i;
  assign conf_req.we    = rab_conf_we_i;

  pulp_core i_core (
    .clk_i,
    .rst_n_i,
    .slv_req_i       (slv_req),
    .slv_req_valid_i (slv_valid_i),
    .slv_req_ready_o (slv_ready_o),
    .slv_rsp_o       (slv_rsp),
    .slv_rsp_valid_o,
    .slv_rsp_ready_i,
    .mst_req_o       (mst_req),
    .mst_req_valid_o (mst_valid_o),
    .mst_req_ready_i (mst_ready_i),
    .mst_rsp_i       (mst_rsp),
    .mst_rsp_valid_i,
    .mst_rsp_ready_o,
    .cfg_req_i       (conf_req),
    .cfg_valid_i     (rab_conf_valid_i),
    .cfg_rdata_o     (rab_conf_rdata_o),
    .cfg_rsp_valid_o (rab_conf_rsp_valid_o),
    .cl_fetch_en_i,
    .cl_eoc_o,
    .cl_busy_o,
    .rab_miss_irq_o,
    .rab_multi_irq_o,
    .rab_prot_irq_o,
    .mbox_irq_o
  );

endmodule

`default_nettype wire

// ==== pulp_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module pulp_core import pulp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  bus_req_t              slv_req_i,
  input  logic                  slv_req_valid_i,
  output logic                  slv_req_ready_o,
  output bus_rsp_t              slv_rsp_o,
  output logic                  slv_rsp_valid_o,
  input  logic                  slv_rsp_ready_i,

  output bus_req_t              mst_req_o,
  output logic                  mst_req_valid_o,
  input  logic                  mst_req_ready_i,
  input  bus_rsp_t              mst_rsp_i,
  input  logic                  mst_rsp_valid_i,
  output logic                  mst_rsp_ready_o,

  input  conf_req_t             cfg_req_i,
  input  logic                  cfg_valid_i,
  output data_t                 cfg_rdata_o,
  output logic                  cfg_rsp_valid_o,

  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,

  output logic                  rab_miss_irq_o,
  output logic                  rab_multi_irq_o,
  output logic                  rab_prot_irq_o,
  output logic                  mbox_irq_o
);

  slice_t [N_SLICES-1:0] slices;
  bus_rsp_t              mbox_rsp, brg_rsp;
  logic                  mbox_rsp_valid, brg_rsp_valid;
  logic                  mbox_req_valid, brg_req_valid, brg_req_ready;
  logic                  mbox_sel, busy_q;

  assign mbox_sel = |(slv_req_i.addr & MBOX_BASE);

  // one transaction in flight on the slave side
  assign slv_req_ready_o = !busy_q && (mbox_sel || brg_req_ready);
  assign mbox_req_valid  = slv_req_valid_i && !busy_q && mbox_sel;
  assign brg_req_valid   = slv_req_valid_i && !busy_q && !mbox_sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (slv_req_valid_i && slv_req_ready_o) begin
      busy_q <= 1'b1;
    end else if (slv_rsp_valid_o && slv_rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  assign slv_rsp_valid_o = mbox_rsp_valid || brg_rsp_valid;
  assign slv_rsp_o       = mbox_rsp_valid ? mbox_rsp : brg_rsp;

  rab_cfg_regs i_cfg (
    .clk_i,
    .rst_n_i,
    .cfg_req_i,
    .cfg_valid_i,
    .cfg_rdata_o,
    .cfg_rsp_valid_o,
    .slices_o        (slices)
  );

  rab_bridge i_bridge (
    .clk_i,
    .rst_n_i,
    .req_i           (slv_req_i),
    .req_valid_i     (brg_req_valid),
    .req_ready_o     (brg_req_ready),
    .rsp_o           (brg_rsp),
    .rsp_valid_o     (brg_rsp_valid),
    .rsp_ready_i     (slv_rsp_ready_i),
    .mst_req_o,
    .mst_req_valid_o,
    .mst_req_ready_i,
    .mst_rsp_i,
    .mst_rsp_valid_i,
    .mst_rsp_ready_o,
    .slices_i        (slices),
    .irq_miss_o      (rab_miss_irq_o),
    .irq_multi_o     (rab_multi_irq_o),
    .irq_prot_o      (rab_prot_irq_o)
  );

  mbox_fifo i_mbox (
    .clk_i,
    .rst_n_i,
    .req_i           (slv_req_i),
    .req_valid_i     (mbox_req_valid),
    .rsp_o           (mbox_rsp),
    .rsp_valid_o     (mbox_rsp_valid),
    .rsp_ready_i     (slv_rsp_ready_i),
    .irq_o           (mbox_irq_o)
  );

  cluster_ctrl i_cl_ctrl (
    .clk_i,
    .rst_n_i,
    .fetch_en_i      (cl_fetch_en_i),
    .busy_o          (cl_busy_o),
    .eoc_o           (cl_eoc_o)
  );

  a_one_rsp_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mbox_rsp_valid && brg_rsp_valid) && (!slv_rsp_valid_o || busy_q));

endmodule

`default_nettype wire

// ==== cluster_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module cluster_ctrl import pulp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic [N_CLUSTERS-1:0] fetch_en_i,
  output logic [N_CLUSTERS-1:0] busy_o,
  output logic [N_CLUSTERS-1:0] eoc_o
);

  logic [N_CLUSTERS-1:0] fetch_q;
  cl_cnt_t               cnt_q [N_CLUSTERS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetch_q <= '0;
      eoc_o   <= '0;
      for (int i = 0; i < N_CLUSTERS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      fetch_q <= fetch_en_i;
      for (int i = 0; i < N_CLUSTERS; i++) begin
        if (fetch_en_i[i] && !fetch_q[i] && !busy_o[i]) begin
          cnt_q[i] <= cl_cnt_t'(CL_RUN_CYCLES);
          eoc_o[i] <= 1'b0;
        end else if (busy_o[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
          // last run cycle, eoc comes up as busy goes down
          if (cnt_q[i] == cl_cnt_t'(1)) begin
            eoc_o[i] <= 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_CLUSTERS; i++) begin
      busy_o[i] = (cnt_q[i] != '0);
    end
  end

endmodule

`default_nettype wire

// ==== mbox_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbox_fifo import pulp_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output bus_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,

  output logic     irq_o
);

  data_t     mem_q [MBOX_DEPTH];
  mbox_ptr_t wr_ptr_q, rd_ptr_q;
  mbox_cnt_t count_q;
  logic      full, empty, push, pop;

  assign full  = (count_q == mbox_cnt_t'(MBOX_DEPTH));
  assign empty = (count_q == '0);
  assign push  = req_valid_i && req_i.we && !full;
  assign pop   = req_valid_i && !req_i.we && !empty;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        count_q  <= count_q + 1'b1;
      end else if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        count_q  <= count_q - 1'b1;
      end
      if (req_valid_i) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i.wdata;
    end
    if (req_valid_i) begin
      rsp_o.rdata <= pop ? mem_q[rd_ptr_q] : '0;
      rsp_o.err   <= req_i.we ? full : empty;
    end
  end

  assign irq_o = !empty;

endmodule

`default_nettype wire

// ==== rab_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module rab_bridge import pulp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  bus_req_t              req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output bus_rsp_t              rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,

  output bus_req_t              mst_req_o,
  output logic                  mst_req_valid_o,
  input  logic                  mst_req_ready_i,
  input  bus_rsp_t              mst_rsp_i,
  input  logic                  mst_rsp_valid_i,
  output logic                  mst_rsp_ready_o,

  input  slice_t [N_SLICES-1:0] slices_i,

  output logic                  irq_miss_o,
  output logic                  irq_multi_o,
  output logic                  irq_prot_o
);

  bridge_state_t state_q, state_d;
  bus_req_t      req_q;
  bus_rsp_t      rsp_q;
  addr_t         xlat_addr;
  logic          hit, multi, prot;
  logic          accept;

  rab_xlat i_xlat (
    .addr_i   (req_i.addr),
    .we_i     (req_i.we),
    .slices_i (slices_i),
    .addr_o   (xlat_addr),
    .hit_o    (hit),
    .multi_o  (multi),
    .prot_o   (prot)
  );

  assign accept = req_valid_i && req_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          // misses and prot violations never reach the master port
          state_d = (hit && !prot) ? ISSUE : RESP;
        end
      end
      ISSUE: begin
        if (mst_req_ready_i) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (mst_rsp_valid_i) begin
          state_d = RESP;
        end
      end
      default: begin
        if (rsp_ready_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      irq_miss_o  <= 1'b0;
      irq_prot_o  <= 1'b0;
      irq_multi_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      irq_miss_o  <= accept && !hit;
      irq_prot_o  <= accept && hit && prot;
      irq_multi_o <= accept && hit && multi && !prot;
    end
  end

  // error response preset on accept, replaced by the master reply
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.addr  <= xlat_addr;
      req_q.wdata <= req_i.wdata;
      req_q.we    <= req_i.we;
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b1;
    end else if (state_q == WAIT_RSP && mst_rsp_valid_i) begin
      rsp_q <= mst_rsp_i;
    end
  end

  assign req_ready_o     = (state_q == IDLE);
  assign mst_req_valid_o = (state_q == ISSUE);
  assign mst_rsp_ready_o = (state_q == WAIT_RSP);
  assign rsp_valid_o     = (state_q == RESP);
  assign mst_req_o       = req_q;
  assign rsp_o           = rsp_q;

  a_mst_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_o && !mst_req_ready_i |=> mst_req_valid_o && $stable(mst_req_o));

  a_irq_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_miss_o || irq_multi_o || irq_prot_o) |=> !(irq_miss_o || irq_multi_o || irq_prot_o));

endmodule

`default_nettype wire

// ==== rab_xlat.sv ====
`timescale 1ns/100ps
`default_nettype none

module rab_xlat import pulp_pkg::*; (
  input  addr_t                 addr_i,
  input  logic                  we_i,
  input  slice_t [N_SLICES-1:0] slices_i,

  output addr_t                 addr_o,
  output logic                  hit_o,
  output logic                  multi_o,
  output logic                  prot_o
);

  logic [N_SLICES-1:0] match;
  slice_t              hit_slice;

  always_comb begin
    for (int i = 0; i < N_SLICES; i++) begin
      match[i] = slices_i[i].en &&
                 (addr_i >= slices_i[i].first) &&
                 (addr_i <= slices_i[i].last);
    end
  end

  // walk downwards so the lowest matching slice is the one kept
  always_comb begin
    hit_slice = '0;
    for (int i = N_SLICES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit_slice = slices_i[i];
      end
    end
  end

  assign hit_o = |match;

  // more than one bit set in the match vector
  assign multi_o = |(match & (match - 1'b1));

  assign prot_o = hit_o && we_i && !hit_slice.wr_ok;

  assign addr_o = addr_i - hit_slice.first + hit_slice.offset;

endmodule

`default_nettype wire

// ==== rab_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module rab_cfg_regs import pulp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  conf_req_t             cfg_req_i,
  input  logic                  cfg_valid_i,
  output data_t                 cfg_rdata_o,
  output logic                  cfg_rsp_valid_o,

  output slice_t [N_SLICES-1:0] slices_o
);

  slice_idx_t  sel;
  conf_field_t field;
  data_t       rd_word;

  assign sel   = cfg_req_i.addr[CONF_AW-1:2];
  assign field = cfg_req_i.addr[1:0];

  always_comb begin
    unique case (field)
      CONF_F_FIRST:  rd_word = slices_o[sel].first;
      CONF_F_LAST:   rd_word = slices_o[sel].last;
      CONF_F_OFFSET: rd_word = slices_o[sel].offset;
      default:       rd_word = data_t'({slices_o[sel].wr_ok, slices_o[sel].en});
    endcase
  end

  // slice table and response pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      slices_o        <= '0;
      cfg_rsp_valid_o <= 1'b0;
    end else begin
      cfg_rsp_valid_o <= cfg_valid_i;
      if (cfg_valid_i && cfg_req_i.we) begin
        unique case (field)
          CONF_F_FIRST:  slices_o[sel].first  <= cfg_req_i.wdata;
          CONF_F_LAST:   slices_o[sel].last   <= cfg_req_i.wdata;
          CONF_F_OFFSET: slices_o[sel].offset <= cfg_req_i.wdata;
          default: begin
            slices_o[sel].en    <= cfg_req_i.wdata[0];
            slices_o[sel].wr_ok <= cfg_req_i.wdata[1];
          end
        endcase
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (cfg_valid_i) begin
      cfg_rdata_o <= cfg_req_i.we ? '0 : rd_word;
    end
  end

  a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_rsp_valid_o |=> !cfg_rsp_valid_o);

endmodule

`default_nettype wire

// ==== pulp_pkg.sv ====
`default_nettype none

package pulp_pkg;

  localparam int unsigned AXI_AW = 32;
  localparam int unsigned AXI_DW = 32;

  localparam int unsigned N_SLICES      = 4;
  localparam int unsigned N_CLUSTERS    = 4;
  localparam int unsigned CL_RUN_CYCLES = 8;
  localparam int unsigned MBOX_DEPTH    = 4;

  // word index into the slice table, slice in the upper bits
  localparam int unsigned CONF_AW = 4;

  typedef logic [AXI_AW-1:0]  addr_t;
  typedef logic [AXI_DW-1:0]  data_t;
  typedef logic [CONF_AW-1:0] conf_addr_t;

  // any slave address with this bit set goes to the mailbox
  localparam addr_t MBOX_BASE = 32'h8000_0000;

  typedef logic [1:0]         conf_field_t;
  typedef logic [CONF_AW-3:0] slice_idx_t;

  localparam conf_field_t CONF_F_FIRST  = 2'd0;
  localparam conf_field_t CONF_F_LAST   = 2'd1;
  localparam conf_field_t CONF_F_OFFSET = 2'd2;
  localparam conf_field_t CONF_F_FLAGS  = 2'd3;

  typedef logic [$clog2(MBOX_DEPTH)-1:0]    mbox_ptr_t;
  typedef logic [$clog2(MBOX_DEPTH+1)-1:0]  mbox_cnt_t;
  typedef logic [$clog2(CL_RUN_CYCLES+1)-1:0] cl_cnt_t;

  typedef struct packed {
    addr_t first;
    addr_t last;
    addr_t offset;
    logic  en;
    logic  wr_ok;
  } slice_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  we;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef struct packed {
    conf_addr_t addr;
    data_t      wdata;
    logic       we;
  } conf_req_t;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    RESP
  } bridge_state_t;

endpackage

`default_nettype wire
